/* source/host_mem_config.svh */
`ifndef HOST_MEM_CONFIG_SVH
`define HOST_MEM_CONFIG_SVH

// Width of a byte address on both the source and the host side
`define HM_ADDR_WIDTH 48

// Width of one data beat in bits
// Each beat therefore moves 8 bytes
`define HM_DATA_WIDTH 64

// Width of the transaction id that the accelerator attaches to a request
`define HM_ID_WIDTH 4

// Source burst length field encoded as beats minus one
`define HM_SRC_LEN_WIDTH 8

// Longest burst in beats that the host memory port accepts
`define HM_MAX_BURST 4

// A host burst must stay inside one page of this many bytes
`define HM_PAGE_BYTES 4096

// Number of reorder slots which is also the number of read credits
`define HM_ROB_DEPTH 16

`endif

/* source/host_mem_pkg.sv */
`default_nettype none

`include "host_mem_config.svh"

package host_mem_pkg;

    // Index of one reorder buffer slot, also used as the host tag
    typedef logic [$clog2(`HM_ROB_DEPTH)-1:0] rob_idx_t;

    // Host burst length as beats minus one
    typedef logic [$clog2(`HM_MAX_BURST)-1:0] host_len_t;

    // Read request from the accelerator
    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0]    addr;
        logic [`HM_SRC_LEN_WIDTH-1:0] len;
        logic [`HM_ID_WIDTH-1:0]      id;
    } src_rd_req_t;

    // Read request toward host memory that is tagged with its first reorder slot
    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        host_len_t                 len;
        rob_idx_t                  tag;
    } host_rd_req_t;

    // One beat from host memory
    // The tag is the base slot of the burst and not of the beat itself
    typedef struct packed {
        logic [`HM_DATA_WIDTH-1:0] data;
        rob_idx_t                  tag;
        logic                      last;
    } host_rd_rsp_t;

    // One beat back to the accelerator in request order
    typedef struct packed {
        logic [`HM_DATA_WIDTH-1:0] data;
        logic [`HM_ID_WIDTH-1:0]   id;
        logic                      last;
    } src_rd_rsp_t;

    // A piece of a source burst that already obeys the host limits
    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        host_len_t                 len;
        logic [`HM_ID_WIDTH-1:0]   id;
        logic                      req_end;
    } piece_t;

endpackage

`default_nettype wire

/* source/host_mem_burst_split.sv */
`timescale 1ns/10ps
`default_nettype none

`include "host_mem_config.svh"

module host_mem_burst_split
    import host_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        src_ar_valid,
    input  src_rd_req_t src_ar,
    output logic        src_ar_ready,
    output logic        piece_valid,
    output piece_t      piece,
    input  logic        piece_ready
);

    localparam int BEAT_BYTES = `HM_DATA_WIDTH / 8;
    localparam int BEAT_BITS = $clog2(BEAT_BYTES);
    localparam int PAGE_BITS = $clog2(`HM_PAGE_BYTES);
    localparam int PAGE_BEATS = `HM_PAGE_BYTES / BEAT_BYTES;

    // Counters must hold a full page of beats as well as a full source burst
    localparam int CNT_W = (($clog2(PAGE_BEATS) > `HM_SRC_LEN_WIDTH) ?
                            $clog2(PAGE_BEATS) : `HM_SRC_LEN_WIDTH) + 1;

    logic                      init_done;
    logic                      busy;
    logic [`HM_ADDR_WIDTH-1:0] cur_addr;
    logic [CNT_W-1:0]          beats_left;
    logic [`HM_ID_WIDTH-1:0]   cur_id;
    logic [CNT_W-1:0]          to_page;
    logic [CNT_W-1:0]          piece_beats;
    logic                      take_req;
    logic                      take_piece;

    // A new request is taken only when every piece of the previous one is gone
    assign src_ar_ready = init_done && !busy;
    assign take_req = src_ar_valid && src_ar_ready;

    // The current piece is always on the output while a request is active
    assign piece_valid = busy;
    assign take_piece = piece_valid && piece_ready;

    // Beats left until the next page boundary
    assign to_page = CNT_W'(PAGE_BEATS) - CNT_W'(cur_addr[PAGE_BITS-1:BEAT_BITS]);

    // Piece size is the smallest of the burst limit, the page room and the rest
    always_comb
    begin
        piece_beats = CNT_W'(`HM_MAX_BURST);
        if (to_page < piece_beats)
        begin
            piece_beats = to_page;
        end
        if (beats_left < piece_beats)
        begin
            piece_beats = beats_left;
        end
    end

    always_comb
    begin
        piece.addr = cur_addr;
        piece.len = host_len_t'(piece_beats - 1'b1);
        piece.id = cur_id;
        // The last piece consumes everything that is left
        piece.req_end = (piece_beats == beats_left);
    end

    // Control state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            init_done <= 1'b0;
            busy <= 1'b0;
        end
        else
        begin
            // Hold off the source for one cycle after reset
            init_done <= 1'b1;
            if (take_req)
            begin
                busy <= 1'b1;
            end
            else if (take_piece && piece.req_end)
            begin
                busy <= 1'b0;
            end
        end
    end

    // Address, remaining beats and id of the active request
    always_ff @(posedge clk)
    begin
        if (take_req)
        begin
            cur_addr <= src_ar.addr;
            beats_left <= CNT_W'(src_ar.len) + 1'b1;
            cur_id <= src_ar.id;
        end
        else if (take_piece)
        begin
            // Step past the bytes that this piece covers
            cur_addr <= cur_addr + (`HM_ADDR_WIDTH'(piece_beats) << BEAT_BITS);
            beats_left <= beats_left - piece_beats;
        end
    end

endmodule

`default_nettype wire

/* source/host_mem_rd_credits.sv */
`timescale 1ns/10ps
`default_nettype none

`include "host_mem_config.svh"

module host_mem_rd_credits
    import host_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    piece_valid,
    input  piece_t                  piece,
    output logic                    piece_ready,
    output logic                    host_ar_valid,
    output host_rd_req_t            host_ar,
    input  logic                    host_ar_ready,
    output logic                    alloc_valid,
    output rob_idx_t                alloc_tag,
    output host_len_t               alloc_len,
    output logic [`HM_ID_WIDTH-1:0] alloc_id,
    output logic                    alloc_end,
    input  logic                    slot_free
);

    localparam int FREE_W = $clog2(`HM_ROB_DEPTH + 1);

    logic [FREE_W-1:0]       free_cnt;
    logic [FREE_W-1:0]       free_next;
    logic [FREE_W-1:0]       need;
    rob_idx_t                alloc_ptr;
    logic [`HM_ID_WIDTH-1:0] held_id;
    logic                    held_end;
    logic                    take_piece;
    logic                    issue;

    // Slots needed by the piece on the input
    assign need = FREE_W'(piece.len) + FREE_W'(1);

    // Take a piece only if the output stage is free and every beat has a slot
    assign piece_ready = (!host_ar_valid || host_ar_ready) && (free_cnt >= need);
    assign take_piece = piece_valid && piece_ready;
    assign issue = host_ar_valid && host_ar_ready;

    always_comb
    begin
        free_next = free_cnt;
        if (take_piece)
        begin
            free_next = free_next - need;
        end
        // A released beat gives back exactly one slot
        if (slot_free)
        begin
            free_next = free_next + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            free_cnt <= FREE_W'(`HM_ROB_DEPTH);
            alloc_ptr <= '0;
            host_ar_valid <= 1'b0;
        end
        else
        begin
            free_cnt <= free_next;
            if (take_piece)
            begin
                // Wraps because the depth is a power of two
                alloc_ptr <= alloc_ptr + rob_idx_t'(need);
                host_ar_valid <= 1'b1;
            end
            else if (issue)
            begin
                host_ar_valid <= 1'b0;
            end
        end
    end

    // The host tag is the first slot reserved for the piece
    always_ff @(posedge clk)
    begin
        if (take_piece)
        begin
            host_ar.addr <= piece.addr;
            host_ar.len <= piece.len;
            host_ar.tag <= alloc_ptr;
            held_id <= piece.id;
            held_end <= piece.req_end;
        end
    end

    // The reorder buffer learns of a burst in the cycle the host accepts it
    assign alloc_valid = issue;
    assign alloc_tag = host_ar.tag;
    assign alloc_len = host_ar.len;
    assign alloc_id = held_id;
    assign alloc_end = held_end;

endmodule

`default_nettype wire

/* source/host_mem_rd_rob.sv */
`timescale 1ns/10ps
`default_nettype none

`include "host_mem_config.svh"

module host_mem_rd_rob
    import host_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_valid,
    input  rob_idx_t                alloc_tag,
    input  host_len_t               alloc_len,
    input  logic [`HM_ID_WIDTH-1:0] alloc_id,
    input  logic                    alloc_end,
    input  logic                    host_r_valid,
    input  host_rd_rsp_t            host_r,
    output logic                    host_r_ready,
    output logic                    src_r_valid,
    output src_rd_rsp_t             src_r,
    input  logic                    src_r_ready,
    output logic                    slot_free
);

    localparam int DEPTH = `HM_ROB_DEPTH;

    // Beat storage and per slot attributes
    logic [`HM_DATA_WIDTH-1:0] data_mem [DEPTH];
    logic [`HM_ID_WIDTH-1:0]   id_mem [DEPTH];
    logic [DEPTH-1:0]          end_flag;

    // A slot is full once its host beat has landed
    logic [DEPTH-1:0]          full;

    // Beats already received for the burst that starts at each slot
    host_len_t                 beat_off [DEPTH];

    rob_idx_t                  head;
    rob_idx_t                  wr_idx;
    logic                      beat_in;
    logic                      beat_out;

    // Every host beat already owns a reserved slot so the host is never stalled
    assign host_r_ready = 1'b1;
    assign beat_in = host_r_valid && host_r_ready;

    // Beat position is its burst base plus the beats seen so far
    assign wr_idx = host_r.tag + rob_idx_t'(beat_off[host_r.tag]);

    // The head slot leaves as soon as it is full
    assign src_r_valid = full[head];
    assign beat_out = src_r_valid && src_r_ready;

    always_comb
    begin
        src_r.data = data_mem[head];
        src_r.id = id_mem[head];
        src_r.last = end_flag[head];
    end

    // Record the id for every slot of a new burst
    // Only the last slot of the final piece of a request carries the end flag
    always_ff @(posedge clk)
    begin
        if (alloc_valid)
        begin
            for (int i = 0; i < `HM_MAX_BURST; i++)
            begin
                if (i <= int'(alloc_len))
                begin
                    id_mem[rob_idx_t'(alloc_tag + i)] <= alloc_id;
                    end_flag[rob_idx_t'(alloc_tag + i)] <= alloc_end &&
                                                           (i == int'(alloc_len));
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_in)
        begin
            data_mem[wr_idx] <= host_r.data;
        end
    end

    // Slot occupancy, burst offsets and the release pointer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full <= '0;
            head <= '0;
            slot_free <= 1'b0;
            for (int i = 0; i < DEPTH; i++)
            begin
                beat_off[i] <= '0;
            end
        end
        else
        begin
            // One credit goes back to the credit stage per released beat
            slot_free <= beat_out;
            if (beat_out)
            begin
                full[head] <= 1'b0;
                head <= head + 1'b1;
            end
            // A beat never lands in the slot being released
            // since that slot is still full
            if (beat_in)
            begin
                full[wr_idx] <= 1'b1;
                // Rewind on the last beat so the base slot is ready for reuse
                beat_off[host_r.tag] <= host_r.last ? '0 : beat_off[host_r.tag] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/host_mem_map.sv */
`timescale 1ns/10ps
`default_nettype none

`include "host_mem_config.svh"

module host_mem_map
    import host_mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         src_ar_valid,
    input  src_rd_req_t  src_ar,
    output logic         src_ar_ready,
    output logic         src_r_valid,
    output src_rd_rsp_t  src_r,
    input  logic         src_r_ready,
    output logic         host_ar_valid,
    output host_rd_req_t host_ar,
    input  logic         host_ar_ready,
    input  logic         host_r_valid,
    input  host_rd_rsp_t host_r,
    output logic         host_r_ready
);

    // Pieces from the splitter to the credit stage
    logic                    piece_valid;
    piece_t                  piece;
    logic                    piece_ready;

    // Slot reservations and releases between the credit stage and the buffer
    logic                    alloc_valid;
    rob_idx_t                alloc_tag;
    host_len_t               alloc_len;
    logic [`HM_ID_WIDTH-1:0] alloc_id;
    logic                    alloc_end;
    logic                    slot_free;

    // Cut source bursts to the host burst limit and page size
    host_mem_burst_split i_burst_split (
        .clk, .rst, .src_ar_valid, .src_ar, .src_ar_ready,
        .piece_valid, .piece, .piece_ready
    );

    // The host port has no flow control so slots are reserved before issue
    host_mem_rd_credits i_rd_credits (
        .clk, .rst, .piece_valid, .piece, .piece_ready,
        .host_ar_valid, .host_ar, .host_ar_ready,
        .alloc_valid, .alloc_tag, .alloc_len, .alloc_id, .alloc_end, .slot_free
    );

    // Put host beats back in request order
    host_mem_rd_rob i_rd_rob (
        .clk, .rst, .alloc_valid, .alloc_tag, .alloc_len, .alloc_id, .alloc_end,
        .host_r_valid, .host_r, .host_r_ready,
        .src_r_valid, .src_r, .src_r_ready, .slot_free
    );

endmodule

`default_nettype wire

/* verif/host_mem_map_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "host_mem_config.svh"

module host_mem_map_tb
    import host_mem_pkg::*;
;

    localparam int PAGE_BITS = $clog2(`HM_PAGE_BYTES);
    // Beats over all five tests times a generous number of cycles per beat
    localparam int TOTAL_BEATS = 3 + 10 + 10 + 23 + 32;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 20 + 400;

    logic         clk;
    logic         rst;
    logic         src_ar_valid;
    src_rd_req_t  src_ar;
    logic         src_ar_ready;
    logic         src_r_valid;
    src_rd_rsp_t  src_r;
    logic         src_r_ready;
    logic         host_ar_valid;
    host_rd_req_t host_ar;
    logic         host_ar_ready;
    logic         host_r_valid;
    host_rd_rsp_t host_r;
    logic         host_r_ready;

    logic [31:0]  lfsr = 32'h0235_9f01;
    int           err_cnt = 0;
    int           chk_cnt = 0;
    int           cycle_cnt = 0;
    int           host_beats_req = 0;
    int           src_beats_out = 0;
    rob_idx_t     next_tag = '0;
    logic         hold_ready = 1'b0;
    logic         host_stall;
    int           host_sel;

    // Expected source beats in request order
    src_rd_rsp_t  exp_q[$];

    // Host bursts accepted but not yet fully returned
    logic [`HM_ADDR_WIDTH-1:0] pend_addr[$];
    rob_idx_t                  pend_tag[$];
    int                        pend_left[$];

    // Every host request seen and the pieces a test expects
    host_rd_req_t host_log[$];
    host_rd_req_t exp_host_q[$];

    host_mem_map i_host_mem_map (
        .clk, .rst, .src_ar_valid, .src_ar, .src_ar_ready,
        .src_r_valid, .src_r, .src_r_ready,
        .host_ar_valid, .host_ar, .host_ar_ready,
        .host_r_valid, .host_r, .host_r_ready
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for each bit taken
    function automatic int rand_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    // Memory contents as a function of the full byte address
    function automatic logic [`HM_DATA_WIDTH-1:0] pattern_data(
        input logic [`HM_ADDR_WIDTH-1:0] addr);
        return {addr[47:32] ^ 16'h5a3c, addr[31:0] ^ 32'hc001_d00d, addr[15:0]};
    endfunction

    function automatic host_rd_req_t make_host_req(input logic [`HM_ADDR_WIDTH-1:0] addr,
                                                  input int beats, input rob_idx_t tag);
        host_rd_req_t req;
        req.addr = addr;
        req.len = host_len_t'(beats - 1);
        req.tag = tag;
        return req;
    endfunction

    task automatic check_src_rsp(input src_rd_rsp_t got, input src_rd_rsp_t exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("** Error: src_r got data %h id %h last %h, expected data %h id %h last %h",
                     got.data, got.id, got.last, exp.data, exp.id, exp.last);
        end
    endtask

    task automatic check_host_req(input host_rd_req_t got, input host_rd_req_t exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("** Error: host_ar got addr %h len %h tag %h, expected addr %h len %h tag %h",
                     got.addr, got.len, got.tag, exp.addr, exp.len, exp.tag);
        end
    endtask

    // Host side of one accepted request checked against the page and tag rules
    task automatic accept_host_req(input host_rd_req_t req);
        int                        beats;
        logic [`HM_ADDR_WIDTH-1:0] last_byte;
        beats = int'(req.len) + 1;
        last_byte = req.addr + `HM_ADDR_WIDTH'(beats * 8 - 1);
        chk_cnt++;
        if ((req.addr >> PAGE_BITS) != (last_byte >> PAGE_BITS))
        begin
            err_cnt++;
            $display("Host burst at address %h crosses a page boundary", req.addr);
        end
        // Tags follow a wrapping pointer that moves by the burst length
        chk_cnt++;
        if (req.tag !== next_tag)
        begin
            err_cnt++;
            $display("** Error: host_ar.tag got %h expected %h", req.tag, next_tag);
        end
        next_tag = next_tag + rob_idx_t'(beats);
        host_beats_req += beats;
        host_log.push_back(req);
        pend_addr.push_back(req.addr);
        pend_tag.push_back(req.tag);
        pend_left.push_back(beats);
    endtask

    // The beat driven by the model was taken so its burst moves on
    task automatic advance_host_burst();
        if (pend_left[host_sel] == 1)
        begin
            pend_addr.delete(host_sel);
            pend_tag.delete(host_sel);
            pend_left.delete(host_sel);
        end
        else
        begin
            pend_addr[host_sel] += 8;
            pend_left[host_sel]--;
        end
    endtask

    task automatic take_src_beat(input src_rd_rsp_t got);
        src_beats_out++;
        if (exp_q.size() == 0)
        begin
            err_cnt++;
            $display("A beat left on src_r while no request was pending");
        end
        else
        begin
            check_src_rsp(got, exp_q.pop_front());
        end
    endtask

    // Host model picks a random pending burst for each beat or idles
    task automatic drive_host_beat();
        if (host_stall)
        begin
            return;
        end
        host_r_valid = 1'b0;
        if (pend_addr.size() != 0 && rand_bits(2) != 0)
        begin
            host_sel = rand_bits(4) % pend_addr.size();
            host_r_valid = 1'b1;
            host_r.data = pattern_data(pend_addr[host_sel]);
            host_r.tag = pend_tag[host_sel];
            host_r.last = (pend_left[host_sel] == 1);
        end
    endtask

    // Monitors sample at the edge and new inputs follow 2 ns later
    always @(posedge clk)
    begin
        host_stall = host_r_valid && !host_r_ready;
        // The host port has no flow control so the adapter must always take beats
        if (host_r_ready !== 1'b1)
        begin
            err_cnt++;
            $display("** Error: host_r_ready got %h expected 1", host_r_ready);
        end
        if (host_ar_valid && host_ar_ready)
        begin
            accept_host_req(host_ar);
        end
        if (host_r_valid && host_r_ready)
        begin
            advance_host_burst();
        end
        if (src_r_valid && src_r_ready)
        begin
            take_src_beat(src_r);
        end
        if (host_beats_req - src_beats_out > `HM_ROB_DEPTH)
        begin
            err_cnt++;
            $display("Host beats outstanding reached %0d, more than the reorder depth",
                     host_beats_req - src_beats_out);
        end
        #2;
        drive_host_beat();
        host_ar_ready = (rand_bits(2) != 0);
        src_r_ready = hold_ready ? 1'b0 : (rand_bits(2) != 0);
    end

    // Queues the expected beats and then hands the request to the adapter
    task automatic send_req(input logic [`HM_ADDR_WIDTH-1:0] addr, input int beats,
                            input logic [`HM_ID_WIDTH-1:0] id);
        src_rd_rsp_t exp;
        for (int i = 0; i < beats; i++)
        begin
            exp.data = pattern_data(addr + `HM_ADDR_WIDTH'(i * 8));
            exp.id = id;
            exp.last = (i == beats - 1);
            exp_q.push_back(exp);
        end
        @(posedge clk);
        #2;
        src_ar_valid = 1'b1;
        src_ar.addr = addr;
        src_ar.len = `HM_SRC_LEN_WIDTH'(beats - 1);
        src_ar.id = id;
        do
        begin
            @(posedge clk);
        end
        while (!src_ar_ready);
        #2;
        src_ar_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pend_addr.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    task automatic compare_host_log();
        chk_cnt++;
        if (host_log.size() != exp_host_q.size())
        begin
            err_cnt++;
            $display("host_ar carried %0d pieces where %0d were expected",
                     host_log.size(), exp_host_q.size());
            return;
        end
        foreach (exp_host_q[i])
        begin
            check_host_req(host_log[i], exp_host_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %s", name, (err_cnt == err_before) ? "passed" : "failed");
    endtask

    task automatic test_single_read();
        int e;
        e = err_cnt;
        send_req(48'h0000_0000_1000, 3, 4'h7);
        wait_drain();
        report_test("single short read", e);
    endtask

    // 10 aligned beats go out as 4, 4 and 2 with tags stepping by the sizes
    task automatic test_burst_limit();
        int       e;
        rob_idx_t b;
        e = err_cnt;
        host_log.delete();
        exp_host_q.delete();
        b = next_tag;
        exp_host_q.push_back(make_host_req(48'h0000_0abc_0100, 4, b));
        exp_host_q.push_back(make_host_req(48'h0000_0abc_0120, 4, b + 4'd4));
        exp_host_q.push_back(make_host_req(48'h0000_0abc_0140, 2, b + 4'd8));
        send_req(48'h0000_0abc_0100, 10, 4'h2);
        wait_drain();
        compare_host_log();
        report_test("burst limit", e);
    endtask

    // Two beats before the boundary and then whole bursts in the next page
    task automatic test_page_cross();
        int       e;
        rob_idx_t b;
        e = err_cnt;
        host_log.delete();
        exp_host_q.delete();
        b = next_tag;
        exp_host_q.push_back(make_host_req(48'h0000_1234_5ff0, 2, b));
        exp_host_q.push_back(make_host_req(48'h0000_1234_6000, 4, b + 4'd2));
        exp_host_q.push_back(make_host_req(48'h0000_1234_6020, 4, b + 4'd6));
        send_req(48'h0000_1234_5ff0, 10, 4'hb);
        wait_drain();
        compare_host_log();
        report_test("page crossing", e);
    endtask

    task automatic test_interleave();
        int e;
        e = err_cnt;
        send_req(48'h0000_2000_0040, 5, 4'h3);
        send_req(48'h0000_3000_0fe8, 7, 4'h9);
        send_req(48'h0000_0040_0100, 3, 4'h5);
        send_req(48'h0000_7777_0000, 8, 4'hc);
        wait_drain();
        report_test("out of order host", e);
    endtask

    // With the source stalled the credits allow exactly one buffer of beats
    task automatic test_credit_backpressure();
        int e;
        e = err_cnt;
        hold_ready = 1'b1;
        fork
            begin
                for (int k = 0; k < 4; k++)
                begin
                    send_req(48'h0000_5000_0000 + `HM_ADDR_WIDTH'(k * 256), 8, 4'(4'ha + k));
                end
            end
            begin
                // The credits are spent once a whole buffer of beats is outstanding
                while (host_beats_req - src_beats_out < `HM_ROB_DEPTH)
                begin
                    @(negedge clk);
                end
                // Keep the source stalled so that a request beyond the credits would show
                repeat (20) @(negedge clk);
                hold_ready = 1'b0;
            end
        join
        wait_drain();
        report_test("credit back-pressure", e);
    endtask

    initial
    begin
        rst = 1'b1;
        src_ar_valid = 1'b0;
        src_ar = '0;
        src_r_ready = 1'b0;
        host_ar_ready = 1'b0;
        host_r_valid = 1'b0;
        host_r = '0;
        host_stall = 1'b0;
        host_sel = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_single_read();
        test_burst_limit();
        test_page_cross();
        test_interleave();
        test_credit_backpressure();
        $display("Tests: 5, checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Ends a run that stops making progress
    initial
    begin
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* host_mem_map.f */
+incdir+source
source/host_mem_pkg.sv
source/host_mem_burst_split.sv
source/host_mem_rd_credits.sv
source/host_mem_rd_rob.sv
source/host_mem_map.sv
verif/host_mem_map_tb.sv

/* Bender.yml */
package:
  name: host_mem_map

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/host_mem_pkg.sv
      - source/host_mem_burst_split.sv
      - source/host_mem_rd_credits.sv
      - source/host_mem_rd_rob.sv
      - source/host_mem_map.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/host_mem_map_tb.sv
